// ==== Makefile ====
# Verilator simulation of the MD5 core

VERILATOR ?= verilator
TOP       ?= tb_md5_core
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -x "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== md5_core.sv ====
`timescale 1ns/1ps

module md5_core (
    input  logic         clk,
    input  logic         reset_n,
    input  logic         start_i,
    input  logic [511:0] msg_i,
    output logic [127:0] digest_o,
    output logic         done_o
);
    import md5_pkg::*;

    msg_idx_t msg_idx;
    word_t    msg_word;

    md5_step_if step_bus ();

    // Step counter and per-step tables
    md5_step_sched u_sched (
        .clk       (clk),
        .reset_n   (reset_n),
        .start_i   (start_i),
        .step_o    (step_bus.sched),
        .msg_idx_o (msg_idx)
    );

    md5_msg_regs u_msg (
        .clk        (clk),
        .load_i     (step_bus.init),
        .msg_i      (msg_i),
        .msg_idx_i  (msg_idx),
        .msg_word_o (msg_word)
    );

    md5_round_datapath u_dp (
        .clk        (clk),
        .reset_n    (reset_n),
        .step_i     (step_bus.dp),
        .msg_word_i (msg_word),
        .digest_o   (digest_o),
        .done_o     (done_o)
    );

endmodule

// ==== md5_msg_regs.sv ====
`timescale 1ns/1ps

module md5_msg_regs (
    input  logic              clk,
    input  logic              load_i,
    input  logic [511:0]      msg_i,
    input  md5_pkg::msg_idx_t msg_idx_i,
    output md5_pkg::word_t    msg_word_o
);
    import md5_pkg::*;

    word_t words [16];

    // Word 0 sits in the low 32 bits of msg_i
    always_ff @(posedge clk) begin
        if (load_i) begin
            for (int i = 0; i < 16; i++) begin
                words[i] <= msg_i[i*32 +: 32];
            end
        end
    end

    assign msg_word_o = words[msg_idx_i]; // Plain read mux

    // Index from the scheduler must be clean for every step of a block
    a_idx_known: assert property (
        @(posedge clk) load_i |=> (!$isunknown(msg_idx_i)) [*NUM_STEPS]
    ) else $error("msg_idx_i unknown during a block");

endmodule

// ==== md5_pkg.sv ====
package md5_pkg;

    ////////////////////////////////////////
    // Basic types
    ////////////////////////////////////////

    typedef logic [31:0] word_t;     // One MD5 word
    typedef logic [5:0]  step_idx_t; // Step 0..63
    typedef logic [3:0]  msg_idx_t;  // Message word 0..15
    typedef logic [4:0]  shift_t;    // Rotate amount 4..23

    // Round function, in round order
    typedef enum logic [1:0] {
        FUNC_F = 2'd0,
        FUNC_G = 2'd1,
        FUNC_H = 2'd2,
        FUNC_I = 2'd3
    } round_func_t;

    localparam int NUM_STEPS = 64;

    ////////////////////////////////////////
    // Constants
    ////////////////////////////////////////

    // Initial chaining values, register form
    localparam word_t IV_A = 32'h67452301;
    localparam word_t IV_B = 32'hefcdab89;
    localparam word_t IV_C = 32'h98badcfe;
    localparam word_t IV_D = 32'h10325476;

    // Four shifts per round, indexed by {round, step[1:0]}
    localparam shift_t SHIFT_TABLE [16] = '{
        5'd7,  5'd12, 5'd17, 5'd22,
        5'd5,  5'd9,  5'd14, 5'd20,
        5'd4,  5'd11, 5'd16, 5'd23,
        5'd6,  5'd10, 5'd15, 5'd21
    };

endpackage

// ==== md5_round_datapath.sv ====
`timescale 1ns/1ps

module md5_round_datapath (
    input  logic           clk,
    input  logic           reset_n,
    md5_step_if.dp         step_i,
    input  md5_pkg::word_t msg_word_i,
    output logic [127:0]   digest_o,
    output logic           done_o
);
    import md5_pkg::*;

    word_t a;
    word_t b;
    word_t c;
    word_t d;
    word_t func_out;
    word_t sum;
    word_t rot;
    word_t new_b;

    ////////////////////////////////////////
    // Step logic
    ////////////////////////////////////////

    always_comb begin
        case (step_i.func)
            FUNC_F:  func_out = (b & c) | (~b & d);
            FUNC_G:  func_out = (b & d) | (c & ~d);
            FUNC_H:  func_out = b ^ c ^ d;
            default: func_out = c ^ (b | ~d);
        endcase
    end

    assign sum   = a + func_out + msg_word_i + step_i.t_const;
    assign rot   = (sum << step_i.shift_amt) | (sum >> (6'd32 - {1'b0, step_i.shift_amt}));
    assign new_b = b + rot;

    // Working registers A to D
    always_ff @(posedge clk) begin
        if (step_i.init) begin
            a <= IV_A;
            b <= IV_B;
            c <= IV_C;
            d <= IV_D;
        end else if (step_i.step_en) begin
            a <= d;     // Rotate roles each step
            d <= c;
            c <= b;
            b <= new_b;
        end
    end

    ////////////////////////////////////////
    // Digest
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            digest_o <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= step_i.finish;
            if (step_i.finish) begin
                digest_o <= {IV_D + d, IV_C + c, IV_B + b, IV_A + a}; // A in low word
            end
        end
    end

    a_ctrl_onehot: assert property (
        @(posedge clk) disable iff (!reset_n)
        $onehot0({step_i.init, step_i.step_en, step_i.finish})
    ) else $error("init, step_en and finish overlap");

endmodule

// ==== md5_step_if.sv ====
`timescale 1ns/1ps

interface md5_step_if;
    import md5_pkg::*;

    logic        init;      // Load initial values
    logic        step_en;   // One of the 64 steps
    round_func_t func;
    shift_t      shift_amt;
    word_t       t_const;   // Sine constant
    logic        finish;    // Form digest

    modport sched (
        output init, step_en, func, shift_amt, t_const, finish
    );

    modport dp (
        input init, step_en, func, shift_amt, t_const, finish
    );

endinterface

// ==== md5_step_sched.sv ====
`timescale 1ns/1ps

module md5_step_sched (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              start_i,
    md5_step_if.sched         step_o,
    output md5_pkg::msg_idx_t msg_idx_o
);
    import md5_pkg::*;

    logic       busy;    // Steps running
    logic       fin_q;   // Finish cycle after step 63
    step_idx_t  cnt;
    logic [1:0] round;
    msg_idx_t   idx;     // Step within round
    word_t      t_const;

    assign round = cnt[5:4];
    assign idx   = cnt[3:0];

    ////////////////////////////////////////
    // Sequencing
    ////////////////////////////////////////

    assign step_o.init    = start_i && !busy && !fin_q; // Start ignored while busy
    assign step_o.step_en = busy;
    assign step_o.finish  = fin_q;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            busy  <= 1'b0;
            fin_q <= 1'b0;
            cnt   <= '0;
        end else begin
            fin_q <= 1'b0;
            if (step_o.init) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == step_idx_t'(NUM_STEPS - 1)) begin
                    busy  <= 1'b0;
                    fin_q <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Per-step controls
    ////////////////////////////////////////

    assign step_o.func      = round_func_t'(round);
    assign step_o.shift_amt = SHIFT_TABLE[{round, idx[1:0]}];
    assign step_o.t_const   = t_const;

    // Message word order modulo 16
    always_comb begin
        case (round)
            2'd0:    msg_idx_o = idx;
            2'd1:    msg_idx_o = idx * 4'd5 + 4'd1;
            2'd2:    msg_idx_o = idx * 4'd3 + 4'd5;
            default: msg_idx_o = idx * 4'd7;
        endcase
    end

    // Sine constants floor(abs(sin(n+1)) * 2^32)
    always_comb begin
        case (cnt)
            6'd0:    t_const = 32'hd76aa478;
            6'd1:    t_const = 32'he8c7b756;
            6'd2:    t_const = 32'h242070db;
            6'd3:    t_const = 32'hc1bdceee;
            6'd4:    t_const = 32'hf57c0faf;
            6'd5:    t_const = 32'h4787c62a;
            6'd6:    t_const = 32'ha8304613;
            6'd7:    t_const = 32'hfd469501;
            6'd8:    t_const = 32'h698098d8;
            6'd9:    t_const = 32'h8b44f7af;
            6'd10:   t_const = 32'hffff5bb1;
            6'd11:   t_const = 32'h895cd7be;
            6'd12:   t_const = 32'h6b901122;
            6'd13:   t_const = 32'hfd987193;
            6'd14:   t_const = 32'ha679438e;
            6'd15:   t_const = 32'h49b40821;
            6'd16:   t_const = 32'hf61e2562; // Round G
            6'd17:   t_const = 32'hc040b340;
            6'd18:   t_const = 32'h265e5a51;
            6'd19:   t_const = 32'he9b6c7aa;
            6'd20:   t_const = 32'hd62f105d;
            6'd21:   t_const = 32'h02441453;
            6'd22:   t_const = 32'hd8a1e681;
            6'd23:   t_const = 32'he7d3fbc8;
            6'd24:   t_const = 32'h21e1cde6;
            6'd25:   t_const = 32'hc33707d6;
            6'd26:   t_const = 32'hf4d50d87;
            6'd27:   t_const = 32'h455a14ed;
            6'd28:   t_const = 32'ha9e3e905;
            6'd29:   t_const = 32'hfcefa3f8;
            6'd30:   t_const = 32'h676f02d9;
            6'd31:   t_const = 32'h8d2a4c8a;
            6'd32:   t_const = 32'hfffa3942; // Round H
            6'd33:   t_const = 32'h8771f681;
            6'd34:   t_const = 32'h6d9d6122;
            6'd35:   t_const = 32'hfde5380c;
            6'd36:   t_const = 32'ha4beea44;
            6'd37:   t_const = 32'h4bdecfa9;
            6'd38:   t_const = 32'hf6bb4b60;
            6'd39:   t_const = 32'hbebfbc70;
            6'd40:   t_const = 32'h289b7ec6;
            6'd41:   t_const = 32'heaa127fa;
            6'd42:   t_const = 32'hd4ef3085;
            6'd43:   t_const = 32'h04881d05;
            6'd44:   t_const = 32'hd9d4d039;
            6'd45:   t_const = 32'he6db99e5;
            6'd46:   t_const = 32'h1fa27cf8;
            6'd47:   t_const = 32'hc4ac5665;
            6'd48:   t_const = 32'hf4292244; // Round I
            6'd49:   t_const = 32'h432aff97;
            6'd50:   t_const = 32'hab9423a7;
            6'd51:   t_const = 32'hfc93a039;
            6'd52:   t_const = 32'h655b59c3;
            6'd53:   t_const = 32'h8f0ccc92;
            6'd54:   t_const = 32'hffeff47d;
            6'd55:   t_const = 32'h85845dd1;
            6'd56:   t_const = 32'h6fa87e4f;
            6'd57:   t_const = 32'hfe2ce6e0;
            6'd58:   t_const = 32'ha3014314;
            6'd59:   t_const = 32'h4e0811a1;
            6'd60:   t_const = 32'hf7537e82;
            6'd61:   t_const = 32'hbd3af235;
            6'd62:   t_const = 32'h2ad7d2bb;
            default: t_const = 32'heb86d391;
        endcase
    end

    // A run of steps only begins from an accepted start
    a_no_step_idle: assert property (
        @(posedge clk) disable iff (!reset_n)
        (step_o.step_en && cnt == '0) |-> $past(step_o.init)
    ) else $error("step_en without an accepted start");

    // Each block is 64 steps then a finish
    a_block_len: assert property (
        @(posedge clk) disable iff (!reset_n)
        step_o.init |=> step_o.step_en [*NUM_STEPS] ##1 step_o.finish
    ) else $error("Block sequence broken");

endmodule

// ==== md5_tests.txt ====
# name, message words 0..15 (word 0 first), expected digest words A B C D
# All values hex, blocks already padded, digest in register form
empty 00000080 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 d98c1dd4 04b2008f 980980e9 7e42f8ec
a 00008061 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000008 00000000 b975c10c a8b6f1c0 e299c331 61267769
abc 80636261 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000018 00000000 98500190 b04fd23c 7d3f96d6 727fe128
message_digest 7373656d 20656761 65676964 00807473 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000070 00000000 7d696bf9 8d93b77c 312f5a52 d061f1aa
alphabet 64636261 68676665 6c6b6a69 706f6e6d 74737271 78777675 00807a79 00000000 00000000 00000000 00000000 00000000 00000000 00000000 000000d0 00000000 d7d3fcc3 00e49261 6c49fb7d 3be167ca
quick_fox 20656854 63697571 7262206b 206e776f 20786f66 706d756a 766f2073 74207265 6c206568 20797a61 80676f64 00000000 00000000 00000000 00000158 00000000 9d7d109e 82b62b37 351dd86b d619a442

// ==== sim.f ====
md5_pkg.sv
md5_step_if.sv
md5_msg_regs.sv
md5_step_sched.sv
md5_round_datapath.sv
md5_core.sv
tb_md5_core.sv

// ==== tb_md5_core.sv ====
`timescale 1ns/1ps

module tb_md5_core;

    localparam string TEST_FILE    = "md5_tests.txt";
    localparam int    RESET_CYCLES = 8;
    localparam int    IDLE_CHECK   = 4;      // Idle cycles checked after reset
    localparam int    DONE_EDGE    = 65;     // 64 steps, then the finish edge
    localparam int    RUN_CYCLES   = 66 + 8; // One block plus the longest gap
    localparam int    WATCH_CYCLES = 40;
    localparam int    INTERFERE_AT = 20;     // Edge count of the second start
    localparam logic [31:0] SEED   = 32'd55947;

    logic         clk = 1'b0;
    logic         reset_n;
    logic         start_i;
    logic [511:0] msg_i;
    logic [127:0] digest_o;
    logic         done_o;

    string        names [$];
    logic [511:0] msgs  [$];
    logic [127:0] exps  [$];   // {D, C, B, A}

    int          mismatch_cnt = 0;
    int          fail_cnt     = 0;
    int          cycle_cnt    = 0;
    int          timeout_limit;
    logic        limit_ready  = 1'b0;
    logic [31:0] lcg_state    = SEED;

    md5_core uut (
        .clk      (clk),
        .reset_n  (reset_n),
        .start_i  (start_i),
        .msg_i    (msg_i),
        .digest_o (digest_o),
        .done_o   (done_o)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // One vector per line, lines starting with # skipped
    task automatic load_vectors();
        int              fd;
        int              code;
        string           line;
        logic [8*24-1:0] nm;
        logic [31:0]     w [20];
        logic [511:0]    msg;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the test vector file %s", TEST_FILE);
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line.getc(0) == "#") continue;
            code = $sscanf(line,
                "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                nm, w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7], w[8], w[9],
                w[10], w[11], w[12], w[13], w[14], w[15], w[16], w[17], w[18], w[19]);
            if (code != 21) begin
                $display("Malformed line in %s: %s", TEST_FILE, line);
                fail_cnt++;
                continue;
            end
            for (int i = 0; i < 16; i++) begin
                msg[i*32 +: 32] = w[i];     // Word 0 in the low bits
            end
            names.push_back(string'(nm));
            msgs.push_back(msg);
            exps.push_back({w[19], w[18], w[17], w[16]});
        end
        $fclose(fd);
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (done_o == 1'b0) else begin
                $display("Mismatch after_reset done_o: expected 0 actual %b", done_o);
                mismatch_cnt++;
            end
            assert (digest_o == '0) else begin
                $display("Mismatch after_reset digest_o: expected %h actual %h",
                         128'd0, digest_o);
                mismatch_cnt++;
            end
        end
    endtask

    // Entered and left on a falling edge
    task automatic run_block(input int t, input logic interfere);
        int           gap;
        int           edge_cnt;
        int           alt;
        logic [127:0] got;
        gap = (lcg_next() >> 16) % 8;
        alt = (t + 1) % names.size();
        repeat (gap) @(negedge clk);
        start_i  = 1'b1;
        msg_i    = msgs[t];
        edge_cnt = -1;
        while (edge_cnt < DONE_EDGE + 8) begin
            @(negedge clk);
            edge_cnt++;                     // Rising edges since the start edge
            if (edge_cnt == 0) start_i = 1'b0;
            if (interfere && edge_cnt == INTERFERE_AT) begin
                start_i = 1'b1;             // Busy, so this one is dropped
                msg_i   = msgs[alt];
            end
            if (interfere && edge_cnt == INTERFERE_AT + 1) start_i = 1'b0;
            if (done_o) break;
        end
        assert (done_o) else begin
            $display("done_o never came for test %0s", names[t]);
            fail_cnt++;
            return;
        end
        assert (edge_cnt == DONE_EDGE) else begin
            $display("Mismatch %0s done edge: expected %0d actual %0d",
                     names[t], DONE_EDGE, edge_cnt);
            mismatch_cnt++;
        end
        got = digest_o;
        assert (got == exps[t]) else begin
            $display("Mismatch %0s digest: expected %h actual %h", names[t], exps[t], got);
            mismatch_cnt++;
        end
        @(negedge clk);
        assert (!done_o) else begin
            $display("done_o stayed high for more than one cycle in test %0s", names[t]);
            fail_cnt++;
        end
        if (interfere) begin
            repeat (WATCH_CYCLES) begin
                @(negedge clk);
                assert (!done_o && digest_o == got) else begin
                    $display("Extra done_o or changed digest after the ignored start in %0s",
                             names[t]);
                    fail_cnt++;
                end
            end
        end
    endtask

    task automatic report_result();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
    endtask

    ////////////////////////////////////////
    // Watchdog and main sequence
    ////////////////////////////////////////

    initial begin : watchdog
        wait (limit_ready);
        while (cycle_cnt < timeout_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: done_o never came within %0d cycles", timeout_limit);
        fail_cnt++;
        report_result();
        $finish;
    end

    initial begin : main
        reset_n = 1'b0;
        start_i = 1'b0;
        msg_i   = '0;
        load_vectors();
        if (names.size() == 0) begin
            $display("No test vectors were read from %s", TEST_FILE);
            fail_cnt++;
            report_result();
            $finish;
        end
        // Plain runs, the ignored-start run and the repeat of the first vector
        timeout_limit = (names.size() + 2) * RUN_CYCLES + RESET_CYCLES + IDLE_CHECK
                        + WATCH_CYCLES + 16;
        limit_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;
        check_idle(IDLE_CHECK);
        for (int t = 0; t < names.size(); t++) begin
            run_block(t, 1'b0);
        end
        run_block((names.size() > 1) ? 1 : 0, 1'b1);
        run_block(0, 1'b0);                 // Fresh IVs and reloaded words
        report_result();
        $finish;
    end

endmodule
